// ==== hdl/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

    // ------------------------------------------------------------
    // geometry and address split
    // ------------------------------------------------------------
    localparam int ADDR_W     = 16;
    localparam int TAG_W      = 4;
    localparam int INDEX_W    = 8;
    localparam int OFFSET_W   = 3;   // word within a line
    localparam int WORD_W     = 16;
    localparam int LINE_WORDS = 8;
    localparam int NUM_WAYS   = 4;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] word;
        logic                byte_sel;
    } cache_addr_t;

    typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

    typedef struct packed {
        logic              read;
        logic              write;
        cache_addr_t       addr;
        logic [WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        EVICT,
        FILL,
        INSTALL
    } ctrl_state_e;

    // a line leaving the array, enough to rebuild its memory address
    typedef struct packed {
        logic               valid;
        logic               dirty;
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        line_t              line;
    } victim_t;

endpackage

// ==== hdl/mem_bus_pkg.sv ====
package mem_bus_pkg;

    localparam int MEM_ADDR_W = 16;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    // one byte transfer, held until the memory acks it
    typedef struct packed {
        mem_op_e                 op;
        logic [MEM_ADDR_W-1:0]   addr;
        logic [7:0]              wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_WB,
        OWNER_FILL
    } bus_owner_e;

endpackage

// ==== hdl/cache_array.sv ====
`timescale 1ns/10ps

module cache_array (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                array_lookup,
    input  cache_cfg_pkg::cache_addr_t          lookup_addr,
    output logic                                hit,
    output logic [cache_cfg_pkg::WORD_W-1:0]    hit_word,
    output cache_cfg_pkg::victim_t              victim,
    input  logic                                write_hit,
    input  logic [cache_cfg_pkg::WORD_W-1:0]    write_word,
    input  logic                                install,
    input  cache_cfg_pkg::line_t                install_line,
    input  logic                                install_dirty
);
    import cache_cfg_pkg::*;

    localparam int NUM_SETS = 1 << INDEX_W;
    localparam int WAY_W    = $clog2(NUM_WAYS);   // also the age width

    logic [NUM_WAYS-1:0] valid_r [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_r [NUM_SETS];
    logic [TAG_W-1:0]    tag_r   [NUM_SETS][NUM_WAYS];
    logic [WAY_W-1:0]    age_r   [NUM_SETS][NUM_WAYS];   // 0 is youngest
    line_t               data_r  [NUM_SETS][NUM_WAYS];

    // context of the last lookup, used by write and install
    logic [INDEX_W-1:0]  idx_q;
    logic [TAG_W-1:0]    tag_q;
    logic [OFFSET_W-1:0] word_q;
    logic [WORD_W-1:0]   wdata_q;
    logic [WAY_W-1:0]    hit_way_q;
    logic [WAY_W-1:0]    vic_way_q;

    logic [NUM_WAYS-1:0] match;
    logic [WAY_W-1:0]    hit_way;
    logic [WAY_W-1:0]    vic_way;
    logic                touch_en;
    logic [INDEX_W-1:0]  touch_idx;
    logic [WAY_W-1:0]    touch_way;

    // ------------------------------------------------------------
    // tag compare and victim choice
    // ------------------------------------------------------------
    always_comb
    begin
        match   = '0;
        hit_way = '0;
        vic_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            match[w] = valid_r[lookup_addr.index][w]
                       && (tag_r[lookup_addr.index][w] == lookup_addr.tag);
            if (match[w])
                hit_way = WAY_W'(w);
            if (age_r[lookup_addr.index][w] == '1)
                vic_way = WAY_W'(w);      // oldest
        end
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (!valid_r[lookup_addr.index][w])
                vic_way = WAY_W'(w);      // a free way beats the oldest
        end
    end

    // one access per cycle at most, so one age update port
    assign touch_en  = (array_lookup && (|match)) || install || write_hit;
    assign touch_idx = array_lookup ? lookup_addr.index : idx_q;
    assign touch_way = array_lookup ? hit_way : (install ? vic_way_q : hit_way_q);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hit <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++)
            begin
                valid_r[s] <= '0;
                dirty_r[s] <= '0;
                for (int w = 0; w < NUM_WAYS; w++)
                    age_r[s][w] <= WAY_W'(w);     // distinct ages from the start
            end
        end
        else
        begin
            if (array_lookup)
                hit <= |match;
            if (touch_en)
            begin
                for (int w = 0; w < NUM_WAYS; w++)
                begin
                    if (age_r[touch_idx][w] < age_r[touch_idx][touch_way])
                        age_r[touch_idx][w] <= age_r[touch_idx][w] + 1'b1;
                end
                age_r[touch_idx][touch_way] <= '0;
            end
            if (write_hit)
                dirty_r[idx_q][hit_way_q] <= 1'b1;
            if (install)
            begin
                valid_r[idx_q][vic_way_q] <= 1'b1;
                dirty_r[idx_q][vic_way_q] <= install_dirty;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (array_lookup)
        begin
            idx_q     <= lookup_addr.index;
            tag_q     <= lookup_addr.tag;
            word_q    <= lookup_addr.word;
            wdata_q   <= write_word;
            hit_way_q <= hit_way;
            vic_way_q <= vic_way;
            hit_word  <= data_r[lookup_addr.index][hit_way][lookup_addr.word*WORD_W +: WORD_W];
            victim    <= '{valid: valid_r[lookup_addr.index][vic_way],
                           dirty: dirty_r[lookup_addr.index][vic_way],
                           tag:   tag_r[lookup_addr.index][vic_way],
                           index: lookup_addr.index,
                           line:  data_r[lookup_addr.index][vic_way]};
        end
        if (write_hit)
            data_r[idx_q][hit_way_q][word_q*WORD_W +: WORD_W] <= wdata_q;
        if (install)
        begin
            data_r[idx_q][vic_way_q] <= install_line;
            tag_r[idx_q][vic_way_q]  <= tag_q;
        end
    end

endmodule

// ==== hdl/cache_controller.sv ====
`timescale 1ns/10ps

module cache_controller (
    input  logic                                clk,
    input  logic                                reset,
    input  cache_cfg_pkg::cpu_req_t             cpu_req,
    input  logic                                cpu_req_valid,
    output logic [cache_cfg_pkg::WORD_W-1:0]    cpu_rdata,
    output logic                                cpu_data_ready,
    output logic                                cpu_stall,
    output logic                                cpu_req_invalid,
    output logic                                array_lookup,
    output cache_cfg_pkg::cache_addr_t          lookup_addr,
    input  logic                                hit,
    input  logic [cache_cfg_pkg::WORD_W-1:0]    hit_word,
    input  cache_cfg_pkg::victim_t              victim,
    output logic                                write_hit,
    output logic                                install,
    output cache_cfg_pkg::line_t                install_line,
    output logic                                install_dirty,
    output logic                                wb_push,
    output cache_cfg_pkg::victim_t              wb_victim,
    input  logic                                wb_full,
    input  logic                                wb_empty,
    output logic                                fill_start,
    output cache_cfg_pkg::cache_addr_t          fill_addr,
    input  logic                                line_ready,
    input  cache_cfg_pkg::line_t                fill_line
);
    import cache_cfg_pkg::*;

    ctrl_state_e state;
    cpu_req_t    req_q;      // request held for the whole miss
    line_t       line_q;     // fetched line with the write word merged
    line_t       merged;
    logic        fill_sent;
    logic        need_wb;

    assign need_wb       = victim.valid && victim.dirty;
    assign cpu_stall     = (state != IDLE);
    assign array_lookup  = (state == IDLE) && cpu_req_valid && (cpu_req.read ^ cpu_req.write);
    assign lookup_addr   = cpu_req.addr;
    assign write_hit     = (state == COMPARE) && hit && req_q.write;
    assign wb_push       = (state == EVICT) && need_wb && !wb_full;
    assign wb_victim     = victim;
    assign fill_start    = (state == FILL) && !fill_sent && wb_empty;  // queue drained first
    assign install       = (state == INSTALL);
    assign install_line  = line_q;
    assign install_dirty = req_q.write;     // write-allocate leaves the line dirty
    assign fill_addr     = '{tag: req_q.addr.tag, index: req_q.addr.index,
                             word: '0, byte_sel: 1'b0};

    always_comb
    begin
        merged = fill_line;
        if (req_q.write)
            merged[req_q.addr.word*WORD_W +: WORD_W] = req_q.wdata;
    end

    // ------------------------------------------------------------
    // request sequencing
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state           <= IDLE;
            fill_sent       <= 1'b0;
            cpu_data_ready  <= 1'b0;
            cpu_req_invalid <= 1'b0;
        end
        else
        begin
            cpu_data_ready  <= 1'b0;
            cpu_req_invalid <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (cpu_req_valid && cpu_req.read && cpu_req.write)
                        cpu_req_invalid <= 1'b1;   // rejected, no stall
                    else if (array_lookup)
                        state <= COMPARE;
                end
                COMPARE:
                begin
                    if (hit)
                    begin
                        cpu_data_ready <= 1'b1;
                        state          <= IDLE;
                    end
                    else
                        state <= EVICT;
                end
                EVICT:
                begin
                    fill_sent <= 1'b0;
                    if (!need_wb || !wb_full)
                        state <= FILL;    // push, if any, goes out this cycle
                end
                FILL:
                begin
                    if (fill_start)
                        fill_sent <= 1'b1;
                    if (line_ready)
                        state <= INSTALL;
                end
                INSTALL:
                begin
                    cpu_data_ready <= 1'b1;
                    state          <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (array_lookup)
            req_q <= cpu_req;
        if ((state == FILL) && line_ready)
            line_q <= merged;
        if ((state == COMPARE) && hit)
            cpu_rdata <= hit_word;
        else if (state == INSTALL)
            cpu_rdata <= line_q[req_q.addr.word*WORD_W +: WORD_W];
    end

endmodule

// ==== hdl/block_fill_buffer.sv ====
`timescale 1ns/10ps

module block_fill_buffer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        fill_start,
    input  cache_cfg_pkg::cache_addr_t  fill_addr,
    output mem_bus_pkg::mem_req_t       req,
    input  logic                        grant,
    input  logic                        ack,
    input  logic [7:0]                  rdata,
    output logic                        line_ready,
    output cache_cfg_pkg::line_t        fill_line
);
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    localparam int BYTES = LINE_WORDS * 2;
    localparam int CNT_W = $clog2(BYTES);

    logic                    busy;
    logic [CNT_W-1:0]        cnt;    // {word, byte}, low byte first
    logic [ADDR_W-CNT_W-1:0] base;   // tag and index of the line
    logic                    take;

    assign take = busy && grant && ack;
    assign req  = '{op: busy ? MEM_READ : MEM_IDLE, addr: {base, cnt}, wdata: '0};

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            cnt        <= '0;
            line_ready <= 1'b0;
        end
        else
        begin
            line_ready <= 1'b0;
            if (fill_start)
            begin
                busy <= 1'b1;
                cnt  <= '0;
            end
            else if (take)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(BYTES - 1))
                begin
                    busy       <= 1'b0;
                    line_ready <= 1'b1;   // one cycle after the last ack
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_start)
            base <= {fill_addr.tag, fill_addr.index};
        if (take)
            fill_line <= {rdata, fill_line[$bits(line_t)-1:8]};  // byte 0 ends at the bottom
    end

endmodule

// ==== hdl/write_back_buffer.sv ====
`timescale 1ns/10ps

module write_back_buffer #(
    parameter int WB_DEPTH = 4
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wb_push,
    input  cache_cfg_pkg::victim_t  wb_victim,
    output logic                    wb_full,
    output logic                    wb_empty,
    output mem_bus_pkg::mem_req_t   req,
    input  logic                    grant,
    input  logic                    ack
);
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    localparam int PTR_W = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;
    localparam int BYTES = LINE_WORDS * 2;
    localparam int CNT_W = $clog2(BYTES);

    victim_t          entries [WB_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [CNT_W-1:0] cnt;       // byte of the head line being written
    victim_t          head;
    logic             do_push;
    logic             take;
    logic             do_pop;

    assign wb_full  = (count == (PTR_W+1)'(WB_DEPTH));
    assign wb_empty = (count == '0);
    assign head     = entries[rd_ptr];
    assign do_push  = wb_push && !wb_full;
    assign take     = !wb_empty && grant && ack;
    assign do_pop   = take && (cnt == CNT_W'(BYTES - 1));

    // address rebuilt from tag, index and byte count
    assign req = '{op:    wb_empty ? MEM_IDLE : MEM_WRITE,
                   addr:  {head.tag, head.index, cnt},
                   wdata: head.line[cnt*8 +: 8]};

    // ------------------------------------------------------------
    // queue pointers
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            cnt    <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (take)
                cnt <= cnt + 1'b1;    // wraps to 0 after the last byte
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            entries[wr_ptr] <= wb_victim;
    end

endmodule

// ==== hdl/memory_arbiter.sv ====
`timescale 1ns/10ps

module memory_arbiter (
    input  mem_bus_pkg::mem_req_t wb_req,
    input  mem_bus_pkg::mem_req_t fill_req,
    output mem_bus_pkg::mem_req_t mem_req,
    input  logic                  mem_ack,
    output logic                  wb_grant,
    output logic                  wb_ack,
    output logic                  fill_grant,
    output logic                  fill_ack
);
    import mem_bus_pkg::*;

    bus_owner_e owner;

    // write-back first so memory never serves a stale line
    always_comb
    begin
        if (wb_req.op != MEM_IDLE)
            owner = OWNER_WB;
        else if (fill_req.op != MEM_IDLE)
            owner = OWNER_FILL;
        else
            owner = OWNER_NONE;
    end

    always_comb
    begin
        case (owner)
            OWNER_WB:   mem_req = wb_req;
            OWNER_FILL: mem_req = fill_req;
            default:    mem_req = '{op: MEM_IDLE, addr: '0, wdata: '0};
        endcase
    end

    assign wb_grant   = (owner == OWNER_WB);
    assign fill_grant = (owner == OWNER_FILL);
    assign wb_ack     = mem_ack && wb_grant;    // ack goes to the owner only
    assign fill_ack   = mem_ack && fill_grant;

endmodule

// ==== hdl/cache_top.sv ====
`timescale 1ns/10ps

module cache_top #(
    parameter int WB_DEPTH = 4
)
(
    input  logic                                clk,
    input  logic                                reset,
    input  cache_cfg_pkg::cpu_req_t             cpu_req,
    input  logic                                cpu_req_valid,
    output logic [cache_cfg_pkg::WORD_W-1:0]    cpu_rdata,
    output logic                                cpu_data_ready,
    output logic                                cpu_stall,
    output logic                                cpu_req_invalid,
    output mem_bus_pkg::mem_req_t               mem_req,
    input  logic [7:0]                          mem_rdata,
    input  logic                                mem_ack
);
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    // controller <-> array
    logic              array_lookup;
    cache_addr_t       lookup_addr;
    logic              hit;
    logic [WORD_W-1:0] hit_word;
    victim_t           victim;
    logic              write_hit;
    logic              install;
    line_t             install_line;
    logic              install_dirty;

    // controller <-> buffers
    logic        wb_push;
    victim_t     wb_victim;
    logic        wb_full;
    logic        wb_empty;
    logic        fill_start;
    cache_addr_t fill_addr;
    logic        line_ready;
    line_t       fill_line;

    // buffers <-> arbiter
    mem_req_t wb_req;
    mem_req_t fill_req;
    logic     wb_grant;
    logic     wb_ack;
    logic     fill_grant;
    logic     fill_ack;

    cache_controller u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .cpu_req         (cpu_req),
        .cpu_req_valid   (cpu_req_valid),
        .cpu_rdata       (cpu_rdata),
        .cpu_data_ready  (cpu_data_ready),
        .cpu_stall       (cpu_stall),
        .cpu_req_invalid (cpu_req_invalid),
        .array_lookup    (array_lookup),
        .lookup_addr     (lookup_addr),
        .hit             (hit),
        .hit_word        (hit_word),
        .victim          (victim),
        .write_hit       (write_hit),
        .install         (install),
        .install_line    (install_line),
        .install_dirty   (install_dirty),
        .wb_push         (wb_push),
        .wb_victim       (wb_victim),
        .wb_full         (wb_full),
        .wb_empty        (wb_empty),
        .fill_start      (fill_start),
        .fill_addr       (fill_addr),
        .line_ready      (line_ready),
        .fill_line       (fill_line)
    );

    cache_array u_array (
        .clk           (clk),
        .reset         (reset),
        .array_lookup  (array_lookup),
        .lookup_addr   (lookup_addr),
        .hit           (hit),
        .hit_word      (hit_word),
        .victim        (victim),
        .write_hit     (write_hit),
        .write_word    (cpu_req.wdata),   // latched by the array at lookup
        .install       (install),
        .install_line  (install_line),
        .install_dirty (install_dirty)
    );

    block_fill_buffer u_fill (
        .clk        (clk),
        .reset      (reset),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .req        (fill_req),
        .grant      (fill_grant),
        .ack        (fill_ack),
        .rdata      (mem_rdata),
        .line_ready (line_ready),
        .fill_line  (fill_line)
    );

    write_back_buffer #(
        .WB_DEPTH (WB_DEPTH)
    ) u_wb (
        .clk       (clk),
        .reset     (reset),
        .wb_push   (wb_push),
        .wb_victim (wb_victim),
        .wb_full   (wb_full),
        .wb_empty  (wb_empty),
        .req       (wb_req),
        .grant     (wb_grant),
        .ack       (wb_ack)
    );

    memory_arbiter u_arb (
        .wb_req     (wb_req),
        .fill_req   (fill_req),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .wb_grant   (wb_grant),
        .wb_ack     (wb_ack),
        .fill_grant (fill_grant),
        .fill_ack   (fill_ack)
    );

endmodule

// ==== tb/tb_mem_model.sv ====
`timescale 1ns/10ps

module tb_mem_model (
    input  logic                  clk,
    input  logic                  reset,
    input  mem_bus_pkg::mem_req_t mem_req,
    output logic [7:0]            mem_rdata,
    output logic                  mem_ack
);
    import mem_bus_pkg::*;

    logic [7:0] mem [65536];
    logic       ack_q   = 1'b0;
    logic [7:0] rdata_q = 8'h00;
    logic       busy    = 1'b0;    // request seen, latency still running
    int         delay   = 0;

    assign mem_ack   = ack_q;
    assign mem_rdata = rdata_q;

    // every byte depends on both halves of its address
    initial
    begin
        for (int a = 0; a < 65536; a++)
            mem[a] = 8'(a) + 8'(a >> 8) + 8'h5A;
    end

    // responses change on the falling edge only
    always @(negedge clk)
    begin
        int left;
        if (reset)
        begin
            ack_q <= 1'b0;
            busy  <= 1'b0;
            delay <= 0;
        end
        else if (ack_q)
            ack_q <= 1'b0;    // requester moves on at the edge after the ack
        else if (mem_req.op != MEM_IDLE)
        begin
            if (busy)
                left = delay;
            else
                left = int'($urandom_range(3, 0));
            if (left == 0)
            begin
                busy  <= 1'b0;
                ack_q <= 1'b1;
                if (mem_req.op == MEM_READ)
                    rdata_q <= mem[mem_req.addr];
                else
                    mem[mem_req.addr] <= mem_req.wdata;
            end
            else
            begin
                busy  <= 1'b1;
                delay <= left - 1;
            end
        end
    end

endmodule

// ==== tb/tb_cache_top.sv ====
`timescale 1ns/10ps

module tb_cache_top;
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_REQS   = 400;
    localparam int REQ_CYCLES = 150;    // dirty miss against a slow memory
    localparam int MAX_CYCLES = MAX_REQS * REQ_CYCLES;

    logic              clk;
    logic              reset;
    cpu_req_t          cpu_req;
    logic              cpu_req_valid;
    logic [WORD_W-1:0] cpu_rdata;
    logic              cpu_data_ready;
    logic              cpu_stall;
    logic              cpu_req_invalid;
    mem_req_t          mem_req;
    logic [7:0]        mem_rdata;
    logic              mem_ack;

    logic [WORD_W-1:0] shadow [32768];   // words the CPU should see
    logic              pend_read;
    logic [WORD_W-1:0] pend_word;
    cache_addr_t       pend_addr;
    logic              expect_hit;
    logic [1:0]        hit_probe = '0;   // cycles since an expected hit was sampled
    logic [3:0]        reject_probe = '0;   // cycles since a rejected request
    int                errors       = 0;
    int                errors_start = 0;
    int                tests_run    = 0;
    int                tests_failed = 0;
    int                cycle_count  = 0;
    int                wb_bytes     = 0;

    cache_top #(
        .WB_DEPTH (4)
    ) UUT (
        .clk             (clk),
        .reset           (reset),
        .cpu_req         (cpu_req),
        .cpu_req_valid   (cpu_req_valid),
        .cpu_rdata       (cpu_rdata),
        .cpu_data_ready  (cpu_data_ready),
        .cpu_stall       (cpu_stall),
        .cpu_req_invalid (cpu_req_invalid),
        .mem_req         (mem_req),
        .mem_rdata       (mem_rdata),
        .mem_ack         (mem_ack)
    );

    tb_mem_model u_mem (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [7:0] pattern_byte(input logic [15:0] a);
        return a[7:0] + a[15:8] + 8'h5A;
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [15:0] a);
        logic [WORD_W-1:0] w;
        w = shadow[a[15:1]];
        return a[0] ? w[15:8] : w[7:0];    // low byte sits at the even address
    endfunction

    function automatic cache_addr_t make_addr(input logic [3:0] tag, input logic [7:0] index,
                                              input logic [2:0] word);
        return '{tag: tag, index: index, word: word, byte_sel: 1'b0};
    endfunction

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (mem_ack && mem_req.op == MEM_WRITE)
            wb_bytes <= wb_bytes + 1;
    end

    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hit_probe    <= '0;
            reject_probe <= '0;
        end
        else
        begin
            hit_probe    <= {hit_probe[0], cpu_req_valid && expect_hit};
            reject_probe <= {reject_probe[2:0], cpu_req_invalid};
        end
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    read_data_check: assert property (@(posedge clk) disable iff (reset)
        (cpu_data_ready && pend_read) |-> (cpu_rdata == pend_word))
    else
    begin
        errors++;
        $display("MISMATCH at %0t: read of %h returned %h, expected %h",
                 $time, pend_addr, cpu_rdata, pend_word);
    end

    write_byte_check: assert property (@(posedge clk) disable iff (reset)
        (mem_ack && mem_req.op == MEM_WRITE) |-> (mem_req.wdata == shadow_byte(mem_req.addr)))
    else
    begin
        errors++;
        $display("MISMATCH at %0t: memory write of %h at %h, expected %h",
                 $time, mem_req.wdata, mem_req.addr, shadow_byte(mem_req.addr));
    end

    hit_latency_check: assert property (@(posedge clk) disable iff (reset)
        hit_probe[1] |-> cpu_data_ready)
    else
    begin
        errors++;
        $display("at %0t: an expected hit did not complete 2 cycles after its request", $time);
    end

    hit_quiet_check: assert property (@(posedge clk) disable iff (reset)
        (|hit_probe) |-> (mem_req.op == MEM_IDLE))
    else
    begin
        errors++;
        $display("at %0t: memory was accessed during an expected hit", $time);
    end

    // the pulse and a few quiet cycles after it
    reject_check: assert property (@(posedge clk) disable iff (reset)
        (cpu_req_invalid || (|reject_probe)) |-> (!cpu_stall && mem_req.op == MEM_IDLE))
    else
    begin
        errors++;
        $display("at %0t: a rejected request stalled the CPU or reached memory", $time);
    end

    // one request, held until the DUT completes or rejects it
    task automatic access(input logic rd, input logic wr, input cache_addr_t addr,
                          input logic [WORD_W-1:0] wdata, input logic hit_expected);
        @(negedge clk);
        cpu_req       = '{read: rd, write: wr, addr: addr, wdata: wdata};
        cpu_req_valid = 1'b1;
        expect_hit    = hit_expected;
        pend_addr     = addr;
        pend_read     = rd && !wr;
        if (wr && !rd)
            shadow[{addr.tag, addr.index, addr.word}] = wdata;
        pend_word = shadow[{addr.tag, addr.index, addr.word}];
        do
        begin
            @(negedge clk);
            cpu_req_valid = 1'b0;
            expect_hit    = 1'b0;
        end
        while (!cpu_data_ready && !cpu_req_invalid);
        if (cpu_req_invalid != (rd && wr))
        begin
            errors++;
            $display("at %0t: request to %h got the wrong kind of response", $time, addr);
        end
    endtask

    task automatic report_test(input string name);
        int found;
        @(negedge clk);    // lets the last completion pass its check
        found = errors - errors_start;
        tests_run++;
        if (found != 0)
            tests_failed++;
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (found == 0) ? "ok" : "failed", found);
        errors_start = errors;
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial
    begin
        cache_addr_t a;
        cache_addr_t b;
        int          wb_before;
        logic        rd_op;
        void'($urandom(63766));
        cpu_req       = '0;
        cpu_req_valid = 1'b0;
        expect_hit    = 1'b0;
        pend_read     = 1'b0;
        pend_word     = '0;
        pend_addr     = '0;
        reset         = 1'b1;
        for (int i = 0; i < 32768; i++)
            shadow[i] = {pattern_byte({i[14:0], 1'b1}), pattern_byte({i[14:0], 1'b0})};
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 8; i++)
            access(1'b1, 1'b0, make_addr(4'(i + 1), 8'(8'h10 + i), 3'(i)), '0, 1'b0);
        report_test("cold reads");

        a = make_addr(4'h3, 8'h20, 3'd5);
        b = make_addr(4'h3, 8'h20, 3'd2);
        access(1'b0, 1'b1, a, 16'hBEEF, 1'b0);    // write-allocate miss
        access(1'b1, 1'b0, a, '0, 1'b1);
        access(1'b0, 1'b1, b, 16'h1234, 1'b1);    // write hit
        access(1'b1, 1'b0, b, '0, 1'b1);
        access(1'b1, 1'b0, a, '0, 1'b1);
        report_test("write then read hit");

        wb_before = wb_bytes;
        for (int t = 0; t < 5; t++)
            access(1'b0, 1'b1, make_addr(4'(t), 8'h40, 3'd3), 16'(16'hA000 + t), 1'b0);
        for (int t = 0; t < 5; t++)
            access(1'b1, 1'b0, make_addr(4'(t), 8'h40, 3'd3), '0, 1'b0);
        if (wb_bytes - wb_before < 16)
        begin
            errors++;
            $display("at %0t: no dirty line was written back to memory", $time);
        end
        report_test("dirty eviction");

        access(1'b1, 1'b1, make_addr(4'h2, 8'h60, 3'd0), 16'hFFFF, 1'b0);
        repeat (4) @(negedge clk);    // bus stays quiet after the rejection
        report_test("invalid request");

        for (int t = 0; t < 4; t++)
            access(1'b1, 1'b0, make_addr(4'(t), 8'h50, 3'd1), '0, 1'b0);
        access(1'b1, 1'b0, make_addr(4'h0, 8'h50, 3'd1), '0, 1'b1);
        access(1'b1, 1'b0, make_addr(4'h4, 8'h50, 3'd1), '0, 1'b0);   // evicts tag 1
        access(1'b1, 1'b0, make_addr(4'h0, 8'h50, 3'd6), '0, 1'b1);
        report_test("lru replacement");

        for (int n = 0; n < 200; n++)
        begin
            a     = make_addr(4'($urandom_range(5, 0)), 8'(8'h70 + $urandom_range(2, 0)),
                              3'($urandom_range(7, 0)));
            rd_op = 1'($urandom_range(1, 0));
            access(rd_op, !rd_op, a, 16'($urandom), 1'b0);
        end
        report_test("random mix");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // run length limit
    initial
    begin
        wait (cycle_count >= MAX_CYCLES);
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/cache_cfg_pkg.sv
hdl/mem_bus_pkg.sv
hdl/cache_array.sv
hdl/cache_controller.sv
hdl/block_fill_buffer.sv
hdl/write_back_buffer.sv
hdl/memory_arbiter.sv
hdl/cache_top.sv
tb/tb_mem_model.sv
tb/tb_cache_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        := tb_cache_top
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
